// File: list.f
texture_pkg.sv
texture_feature_extractor.sv
joint_histogram.sv
histogram_readout.sv
texture_histogram_top.sv
texture_assertions.sv
texture_checker.sv
tb_texture_histogram.sv

// File: Bender.yml
package:
  name: texture_histogram

sources:
  - texture_pkg.sv
  - texture_feature_extractor.sv
  - joint_histogram.sv
  - histogram_readout.sv
  - texture_histogram_top.sv
  - target: test
    files:
      - texture_assertions.sv
      - texture_checker.sv
      - tb_texture_histogram.sv

// File: tb_texture_histogram.sv
`timescale 1ns/100ps
`default_nettype none

module tb_texture_histogram;
  import texture_pkg::*;

  localparam int ROWS          = 16;
  localparam int COLS          = 16;
  localparam int RD_THRESH     = 8;
  localparam int num_frames    = 3;
  localparam int ready_limit   = 2000;
  localparam int done_limit    = 100;
  localparam int readout_limit = 20000;

  logic                  clk;
  logic                  rst_n;
  logic                  start_i;
  logic                  pixel_valid_i;
  logic                  read_en_i;
  logic [pix_w-1:0]      pixel_i;
  logic [count_w-1:0]    hist_count_o;
  logic [bin_addr_w-1:0] hist_bin_o;
  logic                  hist_valid_o;
  logic                  frame_done_o;
  logic                  read_finish_o;
  logic                  const_frame;
  int                    error_count;
  int                    frames_checked;
  int                    timeout_count;
  int unsigned           lcg_state;

  texture_histogram_top #(
    .ROWS      (ROWS),
    .COLS      (COLS),
    .RD_THRESH (RD_THRESH)
  ) dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .pixel_valid_i (pixel_valid_i),
    .read_en_i     (read_en_i),
    .pixel_i       (pixel_i),
    .hist_count_o  (hist_count_o),
    .hist_bin_o    (hist_bin_o),
    .hist_valid_o  (hist_valid_o),
    .frame_done_o  (frame_done_o),
    .read_finish_o (read_finish_o)
  );

  texture_checker #(
    .ROWS      (ROWS),
    .COLS      (COLS),
    .RD_THRESH (RD_THRESH)
  ) chk (
    .clk              (clk),
    .rst_n            (rst_n),
    .pix_valid_i      (pixel_valid_i),
    .pix_i            (pixel_i),
    .const_frame_i    (const_frame),
    .hist_count_i     (hist_count_o),
    .hist_bin_i       (hist_bin_o),
    .hist_valid_i     (hist_valid_o),
    .read_finish_i    (read_finish_o),
    .error_count_o    (error_count),
    .frames_checked_o (frames_checked)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic logic [pix_w-1:0] pixel_value(input int frame);
    case (frame)
      0: return pix_w'(next_rand());
      1: return pix_w'(100 + next_rand() % 24);  // narrow range, rd near threshold.
      default: return 8'h5a;
    endcase
  endfunction

  task automatic finish_run();
    int assert_errors;
    assert_errors = dut.u_assertions.fail_count;
    $display("errors: checker %0d, assertions %0d, timeouts %0d; frames read %0d of %0d",
             error_count, assert_errors, timeout_count, frames_checked, num_frames);
    if (error_count == 0 && assert_errors == 0 && timeout_count == 0 &&
        frames_checked == num_frames) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic wait_ready();
    int cycles;
    for (cycles = 0; cycles < ready_limit; cycles++) begin
      @(posedge clk);
      if (dut.hist_ready) break;
    end
    if (cycles == ready_limit) begin
      $display("timeout: the histogram never became ready after reset");
      timeout_count++;
      finish_run();
    end
  endtask

  task automatic wait_frame_done();
    int cycles;
    for (cycles = 0; cycles < done_limit; cycles++) begin
      @(posedge clk);
      if (frame_done_o) break;
    end
    if (cycles == done_limit) begin
      $display("timeout: frame_done_o did not rise after the last pixel");
      timeout_count++;
      finish_run();
    end
  endtask

  // read_en_i toggles at random, the walk must pause cleanly.
  task automatic read_histogram();
    int cycles;
    for (cycles = 0; cycles < readout_limit; cycles++) begin
      @(posedge clk);
      if (read_finish_o) break;
      read_en_i <= (next_rand() % 4 != 0);
    end
    read_en_i <= 1'b0;
    if (cycles == readout_limit) begin
      $display("timeout: read_finish_o never pulsed during readout");
      timeout_count++;
      finish_run();
    end
  endtask

  task automatic start_frame();
    @(posedge clk);
    start_i <= 1'b1;
    repeat (2) @(posedge clk);
    start_i <= 1'b0;  // falling edge starts the frame.
    repeat (4) @(posedge clk);
  endtask

  task automatic drive_pixel(input logic [pix_w-1:0] value);
    int gap;
    gap = (next_rand() % 4 == 0) ? 1 + next_rand() % 3 : 0;
    repeat (gap) begin
      @(posedge clk);
      pixel_valid_i <= 1'b0;
    end
    @(posedge clk);
    pixel_valid_i <= 1'b1;
    pixel_i       <= value;
  endtask

  task automatic run_frame(input int frame);
    const_frame <= (frame == 2);
    start_frame();
    for (int p = 0; p < ROWS*COLS; p++) begin
      drive_pixel(pixel_value(frame));
    end
    @(posedge clk);
    pixel_valid_i <= 1'b0;
    wait_frame_done();
    read_histogram();
  endtask

  initial begin
    lcg_state     = 85;
    timeout_count = 0;
    rst_n         = 1'b0;
    start_i       = 1'b0;
    pixel_valid_i = 1'b0;
    pixel_i       = '0;
    read_en_i     = 1'b0;
    const_frame   = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    wait_ready();
    for (int f = 0; f < num_frames; f++) begin
      run_frame(f);
    end
    repeat (10) @(posedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

// File: texture_checker.sv
`timescale 1ns/100ps
`default_nettype none

module texture_checker #(
  parameter int ROWS      = 16,
  parameter int COLS      = 16,
  parameter int RD_THRESH = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                pix_valid_i,
  input  logic [texture_pkg::pix_w-1:0]       pix_i,
  input  logic                                const_frame_i,
  input  logic [texture_pkg::count_w-1:0]     hist_count_i,
  input  logic [texture_pkg::bin_addr_w-1:0]  hist_bin_i,
  input  logic                                hist_valid_i,
  input  logic                                read_finish_i,
  output int                                  error_count_o,
  output int                                  frames_checked_o
);
  import texture_pkg::*;

  localparam int interior  = (ROWS - 2) * (COLS - 2);
  localparam int const_bin = (1 << 8) | (8 << 4);  // ci set, ni 8, rd 0.

  int   frame_pix [ROWS*COLS];
  int   exp_hist [num_bins];
  int   seen_hist [num_bins];
  int   pix_cnt;
  int   next_bin;
  int   count_sum;
  logic model_ready;
  logic last_was_final;

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    error_count_o++;
  endtask

  // reference histogram of the interior pixels of the frame just collected.
  function automatic void build_model();
    int c;
    int n;
    int sum;
    int ni;
    int rd;
    int ci;
    for (int b = 0; b < num_bins; b++) begin
      exp_hist[b]  = 0;
      seen_hist[b] = 0;
    end
    for (int r = 1; r < ROWS - 1; r++) begin
      for (int k = 1; k < COLS - 1; k++) begin
        c   = frame_pix[r*COLS + k];
        sum = 0;
        ni  = 0;
        rd  = 0;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            n   = frame_pix[(r + dr)*COLS + k + dc];
            sum = sum + n;
            if (!(dr == 0 && dc == 0)) begin
              if (n >= c) ni++;
              if (((n > c) ? n - c : c - n) > RD_THRESH) rd++;
            end
          end
        end
        ci = (9 * c >= sum) ? 1 : 0;
        exp_hist[ci*256 + ni*16 + rd]++;
      end
    end
  endfunction

  task automatic check_bin();
    if (!model_ready) begin
      report_mismatch("hist_valid_o outside a readout");
    end else begin
      if (hist_bin_i !== bin_addr_w'(next_bin)) begin
        report_mismatch($sformatf("bin %0d delivered, expected bin %0d", hist_bin_i, next_bin));
      end else if (hist_count_i !== count_w'(exp_hist[next_bin])) begin
        report_mismatch($sformatf("bin %0d count %0d, expected %0d",
                                  next_bin, hist_count_i, exp_hist[next_bin]));
      end
      seen_hist[next_bin] = hist_count_i;
      count_sum = count_sum + hist_count_i;
      next_bin++;
    end
  endtask

  task automatic close_walk();
    if (!model_ready) begin
      report_mismatch("read_finish_o without a readout in progress");
    end else begin
      if (!last_was_final) report_mismatch("read_finish_o not right after bin 511");
      if (next_bin != num_bins) report_mismatch($sformatf("%0d bins delivered", next_bin));
      if (count_sum != interior) begin
        report_mismatch($sformatf("counts sum to %0d, expected %0d", count_sum, interior));
      end
      if (const_frame_i && seen_hist[const_bin] != interior) begin
        report_mismatch($sformatf("flat frame bin holds %0d", seen_hist[const_bin]));
      end
      model_ready = 1'b0;
      frames_checked_o++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      pix_cnt          = 0;
      next_bin         = 0;
      count_sum        = 0;
      model_ready      = 1'b0;
      last_was_final   = 1'b0;
      error_count_o    = 0;
      frames_checked_o = 0;
    end else begin
      if (hist_valid_i) check_bin();
      if (read_finish_i) close_walk();
      last_was_final = hist_valid_i && (hist_bin_i == bin_addr_w'(num_bins - 1));
      if (pix_valid_i) begin
        frame_pix[pix_cnt] = pix_i;
        pix_cnt++;
        if (pix_cnt == ROWS*COLS) begin
          build_model();
          pix_cnt     = 0;
          next_bin    = 0;
          count_sum   = 0;
          model_ready = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: texture_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module texture_assertions (
  input logic clk,
  input logic rst_n,
  input logic hist_valid_i,
  input logic read_finish_i,
  input logic frame_done_i,
  input logic feat_valid_i
);
  int fail_count = 0;

  // registers settle on the first reset edge, so look one cycle later.
  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !hist_valid_i && !read_finish_i && !frame_done_i && !feat_valid_i)
    else begin
      fail_count++;
      $error("a valid or done output was active during reset");
    end

  finish_single: assert property (@(posedge clk) disable iff (!rst_n)
    read_finish_i |=> !read_finish_i)
    else begin
      fail_count++;
      $error("read_finish_o lasted more than one cycle");
    end

  valid_needs_done: assert property (@(posedge clk) disable iff (!rst_n)
    hist_valid_i |-> frame_done_i)
    else begin
      fail_count++;
      $error("hist_valid_o high while frame_done_o was low");
    end

endmodule

bind texture_histogram_top texture_assertions u_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .hist_valid_i  (hist_valid_o),
  .read_finish_i (read_finish_o),
  .frame_done_i  (frame_done_o),
  .feat_valid_i  (feat_valid)
);

`default_nettype wire

// File: texture_histogram_top.sv
`timescale 1ns/100ps
`default_nettype none

module texture_histogram_top #(
  parameter int ROWS      = 16,
  parameter int COLS      = 16,
  parameter int RD_THRESH = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start_i,
  input  logic                                pixel_valid_i,
  input  logic                                read_en_i,
  input  logic [texture_pkg::pix_w-1:0]       pixel_i,
  output logic [texture_pkg::count_w-1:0]     hist_count_o,
  output logic [texture_pkg::bin_addr_w-1:0]  hist_bin_o,
  output logic                                hist_valid_o,
  output logic                                frame_done_o,
  output logic                                read_finish_o
);
  import texture_pkg::*;

  logic                  start_q;
  logic                  frame_start;
  logic                  hist_ready;
  logic                  pix_accept;
  bin_addr_u             feat;
  logic                  feat_valid;
  logic                  frame_last;
  logic                  rd_req;
  logic [bin_addr_w-1:0] rd_addr;
  logic [count_w-1:0]    rd_data;

  // falling edge of start, one cycle wide.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_q     <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      start_q     <= start_i;
      frame_start <= start_q & ~start_i;
    end
  end

  assign pix_accept = pixel_valid_i & hist_ready;  // pixels dropped during the clear sweep.

  texture_feature_extractor #(
    .ROWS      (ROWS),
    .COLS      (COLS),
    .RD_THRESH (RD_THRESH)
  ) u_extractor (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_start_i (frame_start),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pix_accept),
    .feat_o        (feat),
    .feat_valid_o  (feat_valid),
    .frame_last_o  (frame_last)
  );

  joint_histogram u_histogram (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_start_i (frame_start),
    .feat_i        (feat),
    .feat_valid_i  (feat_valid),
    .frame_last_i  (frame_last),
    .rd_req_i      (rd_req),
    .rd_addr_i     (rd_addr),
    .rd_data_o     (rd_data),
    .ready_o       (hist_ready),
    .frame_done_o  (frame_done_o)
  );

  histogram_readout u_readout (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_start_i (frame_start),
    .read_en_i     (read_en_i),
    .frame_done_i  (frame_done_o),
    .rd_req_o      (rd_req),
    .rd_addr_o     (rd_addr),
    .rd_data_i     (rd_data),
    .hist_count_o  (hist_count_o),
    .hist_bin_o    (hist_bin_o),
    .hist_valid_o  (hist_valid_o),
    .read_finish_o (read_finish_o)
  );

endmodule

`default_nettype wire

// File: histogram_readout.sv
`timescale 1ns/100ps
`default_nettype none

module histogram_readout (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                frame_start_i,
  input  logic                                read_en_i,
  input  logic                                frame_done_i,
  output logic                                rd_req_o,
  output logic [texture_pkg::bin_addr_w-1:0]  rd_addr_o,
  input  logic [texture_pkg::count_w-1:0]     rd_data_i,
  output logic [texture_pkg::count_w-1:0]     hist_count_o,
  output logic [texture_pkg::bin_addr_w-1:0]  hist_bin_o,
  output logic                                hist_valid_o,
  output logic                                read_finish_o
);
  import texture_pkg::*;

  localparam logic [bin_addr_w-1:0] last_bin = bin_addr_w'(num_bins - 1);

  logic [bin_addr_w-1:0] addr_q;
  logic                  walk_done;  // set after bin 511, held until next start.

  assign rd_req_o  = read_en_i & frame_done_i & ~walk_done;
  assign rd_addr_o = addr_q;

  always_ff @(posedge clk) begin
    if (!rst_n || frame_start_i) begin
      addr_q        <= '0;
      walk_done     <= 1'b0;
      hist_valid_o  <= 1'b0;
      read_finish_o <= 1'b0;
    end else begin
      hist_valid_o  <= rd_req_o;
      read_finish_o <= hist_valid_o && (hist_bin_o == last_bin);
      if (rd_req_o) begin
        addr_q <= addr_q + 1'b1;  // wraps back to bin 0.
        if (addr_q == last_bin) walk_done <= 1'b1;
      end
    end
  end

  // bin label lines up with the count returned a cycle later.
  always_ff @(posedge clk) begin
    if (rd_req_o) hist_bin_o <= addr_q;
  end

  assign hist_count_o = rd_data_i;

endmodule

`default_nettype wire

// File: joint_histogram.sv
`timescale 1ns/100ps
`default_nettype none

module joint_histogram (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                frame_start_i,
  input  texture_pkg::bin_addr_u              feat_i,
  input  logic                                feat_valid_i,
  input  logic                                frame_last_i,
  input  logic                                rd_req_i,
  input  logic [texture_pkg::bin_addr_w-1:0]  rd_addr_i,
  output logic [texture_pkg::count_w-1:0]     rd_data_o,
  output logic                                ready_o,
  output logic                                frame_done_o
);
  import texture_pkg::*;

  logic [count_w-1:0]    mem [num_bins];
  logic [count_w-1:0]    mem_q;
  logic [bin_addr_w-1:0] rd_addr;

  logic                  clearing;
  logic [bin_addr_w-1:0] clr_addr;

  // stage 1 holds the bin being read, stage 2 the bin just written.
  logic                  s1_valid;
  logic                  s1_last;
  logic [bin_addr_w-1:0] s1_addr;
  logic                  s2_valid;
  logic [bin_addr_w-1:0] s2_addr;
  logic [count_w-1:0]    s2_cnt;

  logic [count_w-1:0]    base_cnt;
  logic [count_w-1:0]    new_cnt;

  assign rd_addr = rd_req_i ? rd_addr_i : feat_i.addr;

  // same bin twice in a row: the memory copy is one write behind.
  assign base_cnt = (s2_valid && (s2_addr == s1_addr)) ? s2_cnt : mem_q;
  assign new_cnt  = base_cnt + 1'b1;

  always_ff @(posedge clk) begin
    mem_q <= mem[rd_addr];
    if (clearing) begin
      mem[clr_addr] <= '0;
    end else if (s1_valid) begin
      mem[s1_addr] <= new_cnt;
    end else if (rd_req_i) begin
      mem[rd_addr_i] <= '0;  // clear on read.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clearing     <= 1'b1;
      clr_addr     <= '0;
      s1_valid     <= 1'b0;
      s1_last      <= 1'b0;
      s2_valid     <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      if (clearing) begin
        clr_addr <= clr_addr + 1'b1;
        if (clr_addr == bin_addr_w'(num_bins - 1)) clearing <= 1'b0;
      end
      s1_valid <= feat_valid_i;
      s1_last  <= feat_valid_i & frame_last_i;
      s2_valid <= s1_valid;
      if (frame_start_i) begin
        frame_done_o <= 1'b0;
      end else if (s1_valid && s1_last) begin
        frame_done_o <= 1'b1;  // last update retires this cycle.
      end
    end
  end

  always_ff @(posedge clk) begin
    s1_addr <= feat_i.addr;
    s2_addr <= s1_addr;
    s2_cnt  <= new_cnt;
  end

  assign rd_data_o = mem_q;
  assign ready_o   = ~clearing;

endmodule

`default_nettype wire

// File: texture_feature_extractor.sv
`timescale 1ns/100ps
`default_nettype none

module texture_feature_extractor #(
  parameter int ROWS      = 16,
  parameter int COLS      = 16,
  parameter int RD_THRESH = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           frame_start_i,
  input  logic [texture_pkg::pix_w-1:0]  pixel_i,
  input  logic                           pixel_valid_i,
  output texture_pkg::bin_addr_u         feat_o,
  output logic                           feat_valid_o,
  output logic                           frame_last_o
);
  import texture_pkg::*;

  localparam int row_w = $clog2(ROWS);
  localparam int col_w = $clog2(COLS);
  localparam int sum_w = pix_w + 4;  // nine pixels plus the x9 center.

  logic [row_w-1:0] row_q;
  logic [col_w-1:0] col_q;
  logic             take;
  logic             interior;
  logic             last_pix;

  logic [pix_w-1:0] lb0 [COLS];  // previous row.
  logic [pix_w-1:0] lb1 [COLS];  // two rows back.

  // two registered columns; the third is the one arriving now.
  logic [pix_w-1:0] win [3][2];
  logic [pix_w-1:0] new_col [3];
  logic [pix_w-1:0] w [3][3];

  logic [sum_w-1:0] win_sum;
  logic [sum_w-1:0] center_x9;
  logic [ni_w-1:0]  ni_cnt;
  logic [rd_w-1:0]  rd_cnt;

  assign take = pixel_valid_i & ~frame_start_i;

  // the incoming pixel completes the window centered one row up, one column left.
  assign interior = (row_q >= row_w'(2)) && (col_q >= col_w'(2));
  assign last_pix = (row_q == row_w'(ROWS - 1)) && (col_q == col_w'(COLS - 1));

  assign new_col[0] = lb1[col_q];
  assign new_col[1] = lb0[col_q];
  assign new_col[2] = pixel_i;

  always_comb begin
    for (int r = 0; r < 3; r++) begin
      w[r][0] = win[r][0];
      w[r][1] = win[r][1];
      w[r][2] = new_col[r];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || frame_start_i) begin
      row_q <= '0;
      col_q <= '0;
    end else if (take) begin
      if (col_q == col_w'(COLS - 1)) begin
        col_q <= '0;
        row_q <= (row_q == row_w'(ROWS - 1)) ? '0 : row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      lb1[col_q] <= lb0[col_q];
      lb0[col_q] <= pixel_i;
      for (int r = 0; r < 3; r++) begin
        win[r][0] <= win[r][1];
        win[r][1] <= new_col[r];
      end
    end
  end

  always_comb begin
    logic [pix_w-1:0] diff;
    win_sum   = '0;
    ni_cnt    = '0;
    rd_cnt    = '0;
    diff      = '0;
    center_x9 = (sum_w'(w[1][1]) << 3) + sum_w'(w[1][1]);
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        win_sum = win_sum + sum_w'(w[i][j]);
        if (!(i == 1 && j == 1)) begin
          diff = (w[i][j] >= w[1][1]) ? w[i][j] - w[1][1] : w[1][1] - w[i][j];
          if (w[i][j] >= w[1][1]) ni_cnt = ni_cnt + 1'b1;
          if (diff > RD_THRESH) rd_cnt = rd_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || frame_start_i) begin
      feat_valid_o <= 1'b0;
      frame_last_o <= 1'b0;
    end else begin
      feat_valid_o <= take & interior;
      frame_last_o <= take & last_pix;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      feat_o.fields.ci <= (center_x9 >= win_sum);
      feat_o.fields.ni <= ni_cnt;
      feat_o.fields.rd <= rd_cnt;
    end
  end

endmodule

`default_nettype wire

// File: texture_pkg.sv
`default_nettype none

package texture_pkg;

  localparam int pix_w = 8;
  localparam int bin_addr_w = 9;
  localparam int num_bins = 1 << bin_addr_w;
  localparam int count_w = 16;

  // field widths of the bin address.
  localparam int ci_w = 1;
  localparam int ni_w = 4;
  localparam int rd_w = 4;

  // ci sits in the top bit, rd in the low nibble.
  typedef struct packed {
    logic [ci_w-1:0] ci;
    logic [ni_w-1:0] ni;  // neighbors at or above the center.
    logic [rd_w-1:0] rd;  // neighbors far from the center.
  } feat_t;

  // the extractor fills fields, the memory side indexes the flat word.
  typedef union packed {
    feat_t                 fields;
    logic [bin_addr_w-1:0] addr;
  } bin_addr_u;

endpackage

`default_nettype wire
